// File: filelist.f
common/board_pkg.sv
hdl/strobe_gen.sv
tm1638/tm1638_board_controller.sv
i2s/inmp441_mic_i2s_receiver.sv
hdl/lab_core.sv
hdl/board_specific_top.sv
tb/tm1638_model.sv
tb/tb_board_top.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f filelist.f --top-module tb_board_top \
		-Mdir obj_dir -o tb_board_top
	./obj_dir/tb_board_top | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/tb_board_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_board_top;

    import board_pkg::*;

    localparam int clk_mhz      = 8;
    localparam int strobe_hz    = 20000;
    // a panel frame is 1600 cycles at 8 MHz, this leaves some margin
    localparam int frame_cycles = 2000;
    localparam int frame_limit  = 20 * frame_cycles;
    localparam int i2s_limit    = 1000;

    logic                       clk = 1'b0;
    logic                       reset = 1'b1;
    logic                       sio_clk;
    logic                       sio_stb;
    logic                       sio_data_out;
    logic                       sio_data_oe;
    logic                       sio_data_in;
    logic                       mic_sck;
    logic                       mic_ws;
    logic                       mic_lr;
    logic                       mic_sd = 1'b0;
    logic [tm_w_key-1:0]        panel_keys = '0;
    logic [tm_w_digit-1:0][7:0] panel_seg;
    logic [tm_w_led-1:0]        panel_led;
    int                         frame_count;
    int                         proto_errors;
    logic [mic_w_sample-1:0]    mic_word = '0;
    int                         words_sent = 0;
    int                         errors = 0;
    int                         tests = 0;

    always #4 clk = ~clk;

    board_specific_top
    #(
        .clk_mhz   (clk_mhz),
        .strobe_hz (strobe_hz)
    )
    u_board_specific_top
    (
        .clk          (clk),
        .reset        (reset),
        .sio_clk      (sio_clk),
        .sio_stb      (sio_stb),
        .sio_data_out (sio_data_out),
        .sio_data_oe  (sio_data_oe),
        .sio_data_in  (sio_data_in),
        .mic_sck      (mic_sck),
        .mic_ws       (mic_ws),
        .mic_lr       (mic_lr),
        .mic_sd       (mic_sd)
    );

    tm1638_model u_panel
    (
        .clk          (clk),
        .reset        (reset),
        .sio_clk      (sio_clk),
        .sio_stb      (sio_stb),
        .sio_data_out (sio_data_out),
        .sio_data_oe  (sio_data_oe),
        .sio_data_in  (sio_data_in),
        .key_state    (panel_keys),
        .digit_seg    (panel_seg),
        .led_state    (panel_led),
        .frame_count  (frame_count),
        .proto_errors (proto_errors)
    );

    // lit segments by letter, panel order puts segment a in bit 0
    function automatic logic [7:0] segs_of(input string lit);
        logic [7:0] pat;
        pat = '0;
        for (int i = 0; i < lit.len(); i++)
            pat = pat | (8'd1 << (lit[i] - 8'd97));
        return pat;
    endfunction

    function automatic logic [7:0] hex_pattern(input logic [3:0] nib);
        case (nib)
            4'h0:    return segs_of("abcdef");
            4'h1:    return segs_of("bc");
            4'h2:    return segs_of("abdeg");
            4'h3:    return segs_of("abcdg");
            4'h4:    return segs_of("bcfg");
            4'h5:    return segs_of("acdfg");
            4'h6:    return segs_of("acdefg");
            4'h7:    return segs_of("abc");
            4'h8:    return segs_of("abcdefg");
            4'h9:    return segs_of("abcdfg");
            4'ha:    return segs_of("abcefg");
            4'hb:    return segs_of("cdefg");
            4'hc:    return segs_of("adef");
            4'hd:    return segs_of("bcdeg");
            4'he:    return segs_of("adefg");
            default: return segs_of("aefg");
        endcase
    endfunction

    function automatic int nibble_of(input logic [7:0] pattern);
        int found;
        found = -1;
        for (int n = 0; n < 16; n++)
            if (hex_pattern(4'(n)) == pattern)
                found = n;
        return found;
    endfunction

    function automatic bit digits_match(input int first, input logic [15:0] value);
        bit same;
        same = 1'b1;
        for (int i = 0; i < 4; i++)
            if (panel_seg[3'(first + i)] !== hex_pattern(4'(value >> (4 * i))))
                same = 1'b0;
        return same;
    endfunction

    // counter digits 3..0 read back as a number, -1 if one is not hex
    function automatic int decode_counter();
        int value;
        int nib;
        value = 0;
        for (int i = 0; i < 4; i++)
        begin
            nib = nibble_of(panel_seg[3'(i)]);
            if (nib < 0)
                return -1;
            value = value | (nib << (4 * i));
        end
        return value;
    endfunction

    task automatic abort_run(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic check_segments(input int digit, input logic [7:0] got, input logic [3:0] nib);
        if (got !== hex_pattern(nib))
        begin
            $display("[ERROR] %0t: digit %0d shows %h, expected %h for hex %h",
                     $time, digit, got, hex_pattern(nib), nib);
            errors++;
        end
    endtask

    task automatic check_led(input logic [tm_w_led-1:0] got, input logic [tm_w_led-1:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t: leds %b, expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_digits(input int first, input logic [15:0] value);
        for (int i = 0; i < 4; i++)
            check_segments(first + i, panel_seg[3'(first + i)], 4'(value >> (4 * i)));
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d mismatches", tests, name, errors - errors_before);
    endtask

    task automatic wait_frames(input int n);
        int target;
        int guard;
        target = frame_count + n;
        guard = 0;
        while (frame_count < target && guard < frame_limit)
        begin
            guard++;
            @(posedge clk);
        end
        if (frame_count < target)
            abort_run($sformatf("panel stopped at frame %0d", frame_count));
    endtask

    // i2s slave side, msb lands on the second rising sck after ws falls
    task automatic shift_word(input logic [mic_w_sample-1:0] word);
        logic [mic_w_sample-1:0] bits;
        logic                    ws_q;
        logic                    sck_q;
        int                      guard;
        bits = word;
        ws_q = mic_ws;
        guard = 0;
        @(posedge clk);
        while (!(ws_q === 1'b1 && mic_ws === 1'b0) && guard < i2s_limit)
        begin
            ws_q = mic_ws;
            guard++;
            @(posedge clk);
        end
        if (!(ws_q === 1'b1 && mic_ws === 1'b0))
            abort_run("microphone ws never fell");
        else
        begin
            repeat (mic_w_sample)
            begin
                sck_q = mic_sck;
                guard = 0;
                @(posedge clk);
                while (!(sck_q === 1'b1 && mic_sck === 1'b0) && guard < i2s_limit)
                begin
                    sck_q = mic_sck;
                    guard++;
                    @(posedge clk);
                end
                if (!(sck_q === 1'b1 && mic_sck === 1'b0))
                    abort_run("microphone sck stopped");
                else
                begin
                    mic_sd <= bits[mic_w_sample-1];
                    bits = bits << 1;
                end
            end
        end
    endtask

    // the microphone talks in every frame, like the real part
    initial
    begin
        forever
        begin
            shift_word(mic_word);
            words_sent = words_sent + 1;
        end
    end

    task automatic reset_state_test();
        int e0;
        e0 = errors;
        for (int f = 0; f < 2; f++)
        begin
            wait_frames(1);
            check_led(panel_led, '0);
            check_digits(4, 16'h0000);
        end
        report_test("state after reset", e0);
    endtask

    task automatic protocol_test();
        int e0;
        e0 = errors;
        wait_frames(5);
        check_count(proto_errors, 0, "panel protocol errors");
        report_test("frame protocol", e0);
    endtask

    task automatic key_led_test();
        int         e0;
        logic [7:0] pattern;
        e0 = errors;
        for (int i = 0; i < 3; i++)
        begin
            // change keys on a frame boundary so one whole read sees them
            wait_frames(1);
            pattern = 8'($urandom) & 8'hfe;
            panel_keys <= pattern;
            wait_frames(2);
            check_led(panel_led, pattern);
        end
        panel_keys <= '0;
        report_test("keys to leds", e0);
    endtask

    task automatic mic_test();
        int                      e0;
        int                      w0;
        int                      guard;
        int                      f;
        logic [mic_w_sample-1:0] word;
        e0 = errors;
        for (int i = 0; i < 3; i++)
        begin
            word = 24'($urandom);
            mic_word = word;
            w0 = words_sent;
            guard = 0;
            // the word in flight may be the old one, so wait for two
            while (words_sent < w0 + 2 && guard < 4 * i2s_limit)
            begin
                guard++;
                @(posedge clk);
            end
            if (words_sent < w0 + 2)
                abort_run("microphone words were not sent");
            f = 0;
            while (!digits_match(4, word[23:8]) && f < 4)
            begin
                wait_frames(1);
                f++;
            end
            check_digits(4, word[23:8]);
        end
        // left channel select stays low
        check_level(mic_lr, 1'b0, "microphone lr");
        report_test("microphone digits", e0);
    endtask

    task automatic counter_test();
        int e0;
        int v1;
        int v2;
        e0 = errors;
        panel_keys <= 8'h01;
        wait_frames(3);
        check_digits(0, 16'h0000);
        panel_keys <= 8'h00;
        wait_frames(3);
        v1 = decode_counter();
        wait_frames(1);
        v2 = decode_counter();
        if (v1 < 0 || v2 <= v1)
        begin
            $display("[ERROR] %0t: counter did not grow, read %0d then %0d", $time, v1, v2);
            errors++;
        end
        panel_keys <= 8'h01;
        wait_frames(3);
        check_digits(0, 16'h0000);
        panel_keys <= 8'h00;
        report_test("counter and clear", e0);
    endtask

    initial
    begin
        void'($urandom(26117));
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        reset_state_test();
        protocol_test();
        key_led_test();
        mic_test();
        counter_test();
        check_count(proto_errors, 0, "panel protocol errors over the run");
        $display("%0d tests, %0d errors, %0d frames", tests, errors, frame_count);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tm1638_model.sv
`timescale 1ns/100ps
`default_nettype none

module tm1638_model
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  sio_clk,
    input  logic                                  sio_stb,
    input  logic                                  sio_data_out,
    input  logic                                  sio_data_oe,
    output logic                                  sio_data_in,
    input  logic [board_pkg::tm_w_key-1:0]        key_state,
    output logic [board_pkg::tm_w_digit-1:0][7:0] digit_seg,
    output logic [board_pkg::tm_w_led-1:0]        led_state,
    output int                                    frame_count,
    output int                                    proto_errors
);

    import board_pkg::*;

    logic                       read_bit = 1'b0;
    logic                       stb_q;
    logic                       clk_q;
    logic [1:0]                 grp_exp;
    logic [7:0]                 shreg;
    int                         bits;
    int                         bytes_w;
    int                         reads;
    int                         addr;
    int                         errs;
    int                         frames;
    logic [tm_w_digit-1:0][7:0] dec_seg;
    logic [tm_w_led-1:0]        dec_led;

    assign sio_data_in = read_bit;

    // command that opens each of the four groups of a frame
    function automatic logic [7:0] cmd_for(input logic [1:0] g);
        case (g)
            2'd0:    return tm_cmd_write_auto;
            2'd1:    return tm_cmd_addr0;
            2'd2:    return tm_cmd_display_on;
            default: return tm_cmd_read_keys;
        endcase
    endfunction

    function automatic int bytes_for(input logic [1:0] g);
        return (g == 2'd1) ? 17 : 1;
    endfunction

    task automatic protocol_error(input string what);
        $display("panel model: protocol error at %0t, %s", $time, what);
        errs++;
    endtask

    task automatic take_byte();
        if (bytes_w == 0)
        begin
            if (shreg != cmd_for(grp_exp))
                protocol_error($sformatf("command %h where %h belongs", shreg, cmd_for(grp_exp)));
        end
        else if (grp_exp == 2'd1 && bytes_w <= 16)
        begin
            // even addresses hold digits, odd ones hold an led in bit 0
            addr = bytes_w - 1;
            if (addr % 2 == 0)
                dec_seg[3'(addr / 2)] = shreg;
            else
                dec_led[3'(addr / 2)] = shreg[0];
        end
        bytes_w++;
    endtask

    // byte j of the key read carries key j in bit 0 and key j+4 in bit 4
    task automatic answer_read();
        if (grp_exp != 2'd3 || bytes_w != 1)
            protocol_error("read clock outside the key read");
        if (reads % 8 == 0)
            read_bit <= key_state[3'(reads / 8)];
        else if (reads % 8 == 4)
            read_bit <= key_state[3'(reads / 8 + 4)];
        else
            read_bit <= 1'b0;
        reads++;
    endtask

    task automatic end_group();
        if (bits != 0)
            protocol_error("strobe rose inside a byte");
        if (bytes_w != bytes_for(grp_exp))
            protocol_error($sformatf("group %0d wrote %0d bytes", grp_exp, bytes_w));
        if (reads != ((grp_exp == 2'd3) ? 32 : 0))
            protocol_error($sformatf("group %0d had %0d read clocks", grp_exp, reads));
        if (grp_exp == 2'd3)
        begin
            frames++;
            digit_seg <= dec_seg;
            led_state <= dec_led;
        end
        grp_exp = grp_exp + 2'd1;
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            stb_q = 1'b1;
            clk_q = 1'b1;
            grp_exp = 2'd0;
            shreg = '0;
            bits = 0;
            bytes_w = 0;
            reads = 0;
            errs = 0;
            frames = 0;
            dec_seg = '0;
            dec_led = '0;
            read_bit <= 1'b0;
            digit_seg <= '0;
            led_state <= '0;
            frame_count <= 0;
            proto_errors <= 0;
        end
        else
        begin
            if (sio_stb && !sio_clk)
                protocol_error("clock low while strobe is high");
            if (stb_q && !sio_stb)
            begin
                bits = 0;
                bytes_w = 0;
                reads = 0;
            end
            else if (!stb_q && sio_stb)
                end_group();
            else if (!sio_stb && !clk_q && sio_clk)
            begin
                // lsb first, taken on the rising clock
                if (sio_data_oe)
                begin
                    shreg = {sio_data_out, shreg[7:1]};
                    if (bits == 7)
                    begin
                        take_byte();
                        bits = 0;
                    end
                    else
                        bits++;
                end
                else
                    answer_read();
            end
            stb_q = sio_stb;
            clk_q = sio_clk;
            frame_count <= frames;
            proto_errors <= errs;
        end
    end

endmodule

`default_nettype wire

// File: hdl/board_specific_top.sv
`timescale 1ns/100ps
`default_nettype none

module board_specific_top
#(
    parameter clk_mhz   = 50,
    parameter strobe_hz = 1
)
(
    input  logic clk,
    input  logic reset,
    output logic sio_clk,
    output logic sio_stb,
    output logic sio_data_out,
    output logic sio_data_oe,
    input  logic sio_data_in,
    output logic mic_sck,
    output logic mic_ws,
    output logic mic_lr,
    input  logic mic_sd
);

    import board_pkg::*;

    logic                       tick;
    logic [tm_w_key-1:0]        keys;
    logic [tm_w_led-1:0]        led;
    logic [mic_w_sample-1:0]    sample;
    logic                       sample_valid;
    logic [tm_w_digit-1:0][7:0] abcdefgh;
    logic [tm_w_digit-1:0][7:0] hgfedcba;

    strobe_gen
    #(
        .clk_mhz   (clk_mhz),
        .strobe_hz (strobe_hz)
    )
    u_strobe_gen
    (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    lab_core u_lab_core
    (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .keys         (keys),
        .sample       (sample),
        .sample_valid (sample_valid),
        .led          (led),
        .abcdefgh     (abcdefgh)
    );

    // the panel wants segment a in bit 0
    for (genvar d = 0; d < tm_w_digit; d++)
    begin : g_rev_digit
        for (genvar b = 0; b < 8; b++)
        begin : g_rev_bit
            assign hgfedcba[d][b] = abcdefgh[d][7 - b];
        end
    end

    tm1638_board_controller
    #(
        .clk_mhz (clk_mhz)
    )
    u_tm1638
    (
        .clk          (clk),
        .reset        (reset),
        .hgfedcba     (hgfedcba),
        .led          (led),
        .keys         (keys),
        .sio_clk      (sio_clk),
        .sio_stb      (sio_stb),
        .sio_data_out (sio_data_out),
        .sio_data_oe  (sio_data_oe),
        .sio_data_in  (sio_data_in)
    );

    inmp441_mic_i2s_receiver
    #(
        .clk_mhz (clk_mhz)
    )
    u_microphone
    (
        .clk          (clk),
        .reset        (reset),
        .sd           (mic_sd),
        .sck          (mic_sck),
        .ws           (mic_ws),
        .lr           (mic_lr),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

// File: hdl/lab_core.sv
`timescale 1ns/100ps
`default_nettype none

module lab_core
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  tick,
    input  logic [board_pkg::tm_w_key-1:0]        keys,
    input  logic [board_pkg::mic_w_sample-1:0]    sample,
    input  logic                                  sample_valid,
    output logic [board_pkg::tm_w_led-1:0]        led,
    output logic [board_pkg::tm_w_digit-1:0][7:0] abcdefgh
);

    import board_pkg::*;

    logic [15:0]             counter;
    logic [15:0]             mic_hold;
    logic [4*tm_w_digit-1:0] shown;

    // common hex font, a in bit 7, decimal point off
    function automatic logic [7:0] hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0:    hex_seg = 8'b1111_1100;
            4'h1:    hex_seg = 8'b0110_0000;
            4'h2:    hex_seg = 8'b1101_1010;
            4'h3:    hex_seg = 8'b1111_0010;
            4'h4:    hex_seg = 8'b0110_0110;
            4'h5:    hex_seg = 8'b1011_0110;
            4'h6:    hex_seg = 8'b1011_1110;
            4'h7:    hex_seg = 8'b1110_0000;
            4'h8:    hex_seg = 8'b1111_1110;
            4'h9:    hex_seg = 8'b1111_0110;
            4'ha:    hex_seg = 8'b1110_1110;
            4'hb:    hex_seg = 8'b0011_1110;
            4'hc:    hex_seg = 8'b1001_1100;
            4'hd:    hex_seg = 8'b0111_1010;
            4'he:    hex_seg = 8'b1001_1110;
            default: hex_seg = 8'b1000_1110;
        endcase
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            counter  <= '0;
            mic_hold <= '0;
            led      <= '0;
        end
        else
        begin
            // key 0 holds the counter at zero
            if (keys[0])
                counter <= '0;
            else if (tick)
                counter <= counter + 16'd1;
            if (sample_valid)
                mic_hold <= sample[mic_w_sample-1 -: 16];
            led <= keys;
        end
    end

    // digit i shows nibble i, so the most significant nibble sits on digit 7
    assign shown = {mic_hold, counter};

    for (genvar i = 0; i < tm_w_digit; i++)
    begin : g_digit
        assign abcdefgh[i] = hex_seg(shown[4*i +: 4]);
    end

endmodule

`default_nettype wire

// File: i2s/inmp441_mic_i2s_receiver.sv
`timescale 1ns/100ps
`default_nettype none

module inmp441_mic_i2s_receiver
#(
    parameter clk_mhz = 50
)
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              sd,
    output logic                              sck,
    output logic                              ws,
    output logic                              lr,
    output logic [board_pkg::mic_w_sample-1:0] sample,
    output logic                              sample_valid
);

    import board_pkg::*;

    localparam int sck_half = clk_mhz / 4;
    localparam int w_div    = sck_half > 1 ? $clog2(sck_half) : 1;
    localparam int w_bit    = $clog2(i2s_frame_bits);

    logic [w_div-1:0]        div;
    logic [w_bit-1:0]        bit_cnt;
    logic [w_bit-1:0]        bit_nxt;
    logic [mic_w_sample-1:0] shift;

    // left channel only
    assign lr      = 1'b0;
    assign bit_nxt = bit_cnt + 1'b1;

    always_ff @(posedge clk)
    begin
        sample_valid <= 1'b0;
        if (reset)
        begin
            div     <= '0;
            sck     <= 1'b1;
            ws      <= 1'b1;
            bit_cnt <= '1;
            sample  <= '0;
        end
        else if (div == w_div'(sck_half - 1))
        begin
            div <= '0;
            sck <= ~sck;
            if (sck)
            begin
                // falling edge, advance the frame
                bit_cnt <= bit_nxt;
                ws      <= (bit_nxt >= w_bit'(i2s_frame_bits / 2));
            end
            else if (bit_cnt >= w_bit'(1) && bit_cnt <= w_bit'(mic_w_sample))
            begin
                // rising edge, msb one slot after ws falls
                shift <= {shift[mic_w_sample-2:0], sd};
                if (bit_cnt == w_bit'(mic_w_sample))
                begin
                    sample       <= {shift[mic_w_sample-2:0], sd};
                    sample_valid <= 1'b1;
                end
            end
        end
        else
            div <= div + 1'b1;
    end

    assert property (@(posedge clk) disable iff (reset) $changed(ws) |-> $fell(sck));

endmodule

`default_nettype wire

// File: tm1638/tm1638_board_controller.sv
`timescale 1ns/100ps
`default_nettype none

module tm1638_board_controller
#(
    parameter clk_mhz = 50
)
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [board_pkg::tm_w_digit-1:0][7:0] hgfedcba,
    input  logic [board_pkg::tm_w_led-1:0]        led,
    output logic [board_pkg::tm_w_key-1:0]        keys,
    output logic                                  sio_clk,
    output logic                                  sio_stb,
    output logic                                  sio_data_out,
    output logic                                  sio_data_oe,
    input  logic                                  sio_data_in
);

    import board_pkg::*;

    localparam int half_bit = clk_mhz / 2;
    localparam int w_timer  = half_bit > 1 ? $clog2(half_bit) : 1;

    logic [w_timer-1:0]         timer;
    logic                       step;
    logic                       idle;
    logic [1:0]                 gap_cnt;
    logic [1:0]                 grp;
    logic [4:0]                 byte_cnt;
    logic [2:0]                 bit_cnt;
    logic                       phase;
    logic [4:0]                 last_byte;
    logic [1:0]                 rd_j;
    logic [7:0]                 cur_byte;
    logic [7:0]                 nxt_byte;
    logic [7:0]                 first_byte;
    logic [tm_w_digit-1:0][7:0] snap_seg;
    logic [tm_w_led-1:0]        snap_led;
    logic [tm_w_key-1:0]        rd_keys;

    // byte b of group g; in group 1 even addresses are digits, odd are leds
    function automatic logic [7:0] byte_at(input logic [1:0] g, input logic [4:0] b);
        logic [3:0] addr;
        addr = 4'(b - 5'd1);
        case (g)
            2'd0:    byte_at = tm_cmd_write_auto;
            2'd1:
            begin
                if (b == 5'd0)
                    byte_at = tm_cmd_addr0;
                else if (!addr[0])
                    byte_at = snap_seg[addr[3:1]];
                else
                    byte_at = {7'b0, snap_led[addr[3:1]]};
            end
            2'd2:    byte_at = tm_cmd_display_on;
            default: byte_at = tm_cmd_read_keys;
        endcase
    endfunction

    assign step       = (timer == w_timer'(half_bit - 1));
    assign last_byte  = (grp == 2'd1) ? 5'd16 : (grp == 2'd3) ? 5'd4 : 5'd0;
    assign rd_j       = 2'(byte_cnt - 5'd1);
    assign cur_byte   = byte_at(grp, byte_cnt);
    assign nxt_byte   = byte_at(grp, byte_cnt + 5'd1);
    assign first_byte = byte_at(grp + 2'd1, 5'd0);

    // reset leaves the timer at its end so the first group starts right away
    always_ff @(posedge clk)
    begin
        if (reset)
            timer <= w_timer'(half_bit - 1);
        else if (step)
            timer <= '0;
        else
            timer <= timer + 1'b1;
    end

    // panel contents are frozen for the whole frame
    always_ff @(posedge clk)
    begin
        if (step && idle && gap_cnt == 2'd3 && grp == 2'd3)
        begin
            snap_seg <= hgfedcba;
            snap_led <= led;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            idle         <= 1'b1;
            gap_cnt      <= 2'd3;
            grp          <= 2'd3;
            byte_cnt     <= '0;
            bit_cnt      <= '0;
            phase        <= 1'b0;
            sio_stb      <= 1'b1;
            sio_clk      <= 1'b1;
            sio_data_out <= 1'b1;
            sio_data_oe  <= 1'b0;
            rd_keys      <= '0;
            keys         <= '0;
        end
        else if (step)
        begin
            if (idle)
            begin
                if (gap_cnt == 2'd3)
                begin
                    idle         <= 1'b0;
                    grp          <= grp + 2'd1;
                    byte_cnt     <= '0;
                    bit_cnt      <= '0;
                    phase        <= 1'b0;
                    sio_stb      <= 1'b0;
                    sio_clk      <= 1'b0;
                    sio_data_oe  <= 1'b1;
                    sio_data_out <= first_byte[0];
                end
                else
                    gap_cnt <= gap_cnt + 2'd1;
            end
            else if (!phase)
            begin
                // rising edge, the panel takes the bit here
                phase   <= 1'b1;
                sio_clk <= 1'b1;
            end
            else
            begin
                // key j on bit 0, key j+4 on bit 4
                if (grp == 2'd3 && byte_cnt != 5'd0)
                begin
                    if (bit_cnt == 3'd0)
                        rd_keys[{1'b0, rd_j}] <= sio_data_in;
                    if (bit_cnt == 3'd4)
                        rd_keys[{1'b1, rd_j}] <= sio_data_in;
                end
                phase <= 1'b0;
                if (bit_cnt != 3'd7)
                begin
                    bit_cnt      <= bit_cnt + 3'd1;
                    sio_clk      <= 1'b0;
                    sio_data_out <= cur_byte[bit_cnt + 3'd1];
                end
                else if (byte_cnt != last_byte)
                begin
                    byte_cnt     <= byte_cnt + 5'd1;
                    bit_cnt      <= '0;
                    sio_clk      <= 1'b0;
                    sio_data_out <= nxt_byte[0];
                    // release the line once the read command is out
                    sio_data_oe  <= (grp != 2'd3);
                end
                else
                begin
                    idle         <= 1'b1;
                    gap_cnt      <= '0;
                    sio_stb      <= 1'b1;
                    sio_data_oe  <= 1'b0;
                    sio_data_out <= 1'b1;
                    if (grp == 2'd3)
                        keys <= rd_keys;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) sio_stb |-> sio_clk);

    assert property (@(posedge clk) disable iff (reset)
        (!idle && grp == 2'd3 && byte_cnt != 5'd0) |-> !sio_data_oe);

endmodule

`default_nettype wire

// File: hdl/strobe_gen.sv
`timescale 1ns/100ps
`default_nettype none

module strobe_gen
#(
    parameter clk_mhz   = 50,
    parameter strobe_hz = 1
)
(
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int period = clk_mhz * 1000000 / strobe_hz;
    localparam int w_cnt  = period > 1 ? $clog2(period) : 1;

    logic [w_cnt-1:0] cnt;

    // down-counter, tick on each reload
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cnt  <= w_cnt'(period - 1);
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= w_cnt'(period - 1);
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: common/board_pkg.sv
`default_nettype none

package board_pkg;

    // front panel geometry
    localparam int tm_w_digit = 8;
    localparam int tm_w_key   = 8;
    localparam int tm_w_led   = 8;

    // microphone sample and i2s framing
    localparam int mic_w_sample   = 24;

    // serial clocks per ws frame, left half is the first 32
    localparam int i2s_frame_bits = 64;

    // tm1638 command bytes

    // data write, auto-increment address
    localparam logic [7:0] tm_cmd_write_auto = 8'h40;

    // start address 0
    localparam logic [7:0] tm_cmd_addr0      = 8'hc0;

    // display on, full brightness
    localparam logic [7:0] tm_cmd_display_on = 8'h8f;

    // key scan read
    localparam logic [7:0] tm_cmd_read_keys  = 8'h42;

endpackage

`default_nettype wire
